/* Makefile */
SRCS = $(shell cat src.f)

obj_dir/Vcore_id_ex_tb: src.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module core_id_ex_tb -f src.f

run: obj_dir/Vcore_id_ex_tb
	./obj_dir/Vcore_id_ex_tb

clean:
	rm -rf obj_dir

.PHONY: run clean

/* hdl/core_id_ex.sv */
`timescale 1ns/1ps
`default_nettype none

module core_id_ex (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          instr_valid_i,
    input  wire rv_pkg::inst_t instr_i,
    input  wire rv_pkg::xlen_t pc_i,
    output logic               wb_en_o,
    output rv_pkg::reg_idx_t   wb_rd_o,
    output rv_pkg::xlen_t      wb_data_o,
    output logic               redirect_o,
    output rv_pkg::xlen_t      target_o
);
    import rv_pkg::*;

    // decode side
    reg_idx_t  rs1_idx;
    reg_idx_t  rs2_idx;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     id_pc;
    inst_t     id_instr;
    xlen_t     id_imm;
    alu_op_e   id_aluctr;
    src1_sel_e id_src1sel;
    src2_sel_e id_src2sel;
    logic      id_is_jal;
    logic      id_is_jalr;
    logic      id_is_brc;
    logic      id_wben;

    // execute side
    xlen_t     ex_pc;
    inst_t     ex_instr;
    xlen_t     ex_imm;
    xlen_t     ex_rs1;
    xlen_t     ex_rs2;
    alu_op_e   ex_aluctr;
    logic      ex_is_jalr;
    logic      ex_is_jal;
    logic      ex_is_brc;
    src1_sel_e ex_src1sel;
    src2_sel_e ex_src2sel;
    logic      ex_wben;
    reg_idx_t  ex_rs1_idx;
    reg_idx_t  ex_rs2_idx;

    id_decode u_id_decode (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rs1_idx_o     (rs1_idx),
        .rs2_idx_o     (rs2_idx),
        .pc_o          (id_pc),
        .instr_o       (id_instr),
        .imm_o         (id_imm),
        .aluctr_o      (id_aluctr),
        .src1sel_o     (id_src1sel),
        .src2sel_o     (id_src2sel),
        .is_jal_o      (id_is_jal),
        .is_jalr_o     (id_is_jalr),
        .is_brc_o      (id_is_brc),
        .wben_o        (id_wben)
    );

    // written from the registered execute result
    reg_file u_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_idx_i  (rs1_idx),
        .rs2_idx_i  (rs2_idx),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (wb_en_o),
        .wr_idx_i   (wb_rd_o),
        .wr_data_i  (wb_data_o)
    );

    ex_reg u_ex_reg (
        .clk              (clk),
        .rst_n            (rst_n),
        .pc_ex_reg_i      (id_pc),
        .instr_ex_reg_i   (id_instr),
        .imm_ex_reg_i     (id_imm),
        .rs1_ex_reg_i     (rs1_data),
        .rs2_ex_reg_i     (rs2_data),
        .aluctr_ex_reg_i  (id_aluctr),
        .is_jalr_ex_reg_i (id_is_jalr),
        .is_jal_ex_reg_i  (id_is_jal),
        .is_brc_ex_reg_i  (id_is_brc),
        .src1sel_ex_reg_i (id_src1sel),
        .src2sel_ex_reg_i (id_src2sel),
        .wben_ex_reg_i    (id_wben),
        .rs1_idx_ex_reg_i (rs1_idx),
        .rs2_idx_ex_reg_i (rs2_idx),
        .pc_ex_reg_o      (ex_pc),
        .instr_ex_reg_o   (ex_instr),
        .imm_ex_reg_o     (ex_imm),
        .rs1_ex_reg_o     (ex_rs1),
        .rs2_ex_reg_o     (ex_rs2),
        .aluctr_ex_reg_o  (ex_aluctr),
        .is_jalr_ex_reg_o (ex_is_jalr),
        .is_jal_ex_reg_o  (ex_is_jal),
        .is_brc_ex_reg_o  (ex_is_brc),
        .src1sel_ex_reg_o (ex_src1sel),
        .src2sel_ex_reg_o (ex_src2sel),
        .wben_ex_reg_o    (ex_wben),
        .rs1_idx_ex_reg_o (ex_rs1_idx),
        .rs2_idx_ex_reg_o (ex_rs2_idx)
    );

    ex_stage u_ex_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc_i       (ex_pc),
        .instr_i    (ex_instr),
        .imm_i      (ex_imm),
        .rs1_i      (ex_rs1),
        .rs2_i      (ex_rs2),
        .aluctr_i   (ex_aluctr),
        .is_jalr_i  (ex_is_jalr),
        .is_jal_i   (ex_is_jal),
        .is_brc_i   (ex_is_brc),
        .src1sel_i  (ex_src1sel),
        .src2sel_i  (ex_src2sel),
        .wben_i     (ex_wben),
        .rs1_idx_i  (ex_rs1_idx),
        .rs2_idx_i  (ex_rs2_idx),
        .wb_en_o    (wb_en_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o),
        .redirect_o (redirect_o),
        .target_o   (target_o)
    );

endmodule

`default_nettype wire

/* hdl/ex_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_reg (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire rv_pkg::xlen_t     pc_ex_reg_i,
    input  wire rv_pkg::inst_t     instr_ex_reg_i,
    input  wire rv_pkg::xlen_t     imm_ex_reg_i,
    input  wire rv_pkg::xlen_t     rs1_ex_reg_i,
    input  wire rv_pkg::xlen_t     rs2_ex_reg_i,
    input  wire rv_pkg::alu_op_e   aluctr_ex_reg_i,
    input  wire logic              is_jalr_ex_reg_i,
    input  wire logic              is_jal_ex_reg_i,
    input  wire logic              is_brc_ex_reg_i,
    input  wire rv_pkg::src1_sel_e src1sel_ex_reg_i,
    input  wire rv_pkg::src2_sel_e src2sel_ex_reg_i,
    input  wire logic              wben_ex_reg_i,
    input  wire rv_pkg::reg_idx_t  rs1_idx_ex_reg_i,
    input  wire rv_pkg::reg_idx_t  rs2_idx_ex_reg_i,
    output rv_pkg::xlen_t          pc_ex_reg_o,
    output rv_pkg::inst_t          instr_ex_reg_o,
    output rv_pkg::xlen_t          imm_ex_reg_o,
    output rv_pkg::xlen_t          rs1_ex_reg_o,
    output rv_pkg::xlen_t          rs2_ex_reg_o,
    output rv_pkg::alu_op_e        aluctr_ex_reg_o,
    output logic                   is_jalr_ex_reg_o,
    output logic                   is_jal_ex_reg_o,
    output logic                   is_brc_ex_reg_o,
    output rv_pkg::src1_sel_e      src1sel_ex_reg_o,
    output rv_pkg::src2_sel_e      src2sel_ex_reg_o,
    output logic                   wben_ex_reg_o,
    output rv_pkg::reg_idx_t       rs1_idx_ex_reg_o,
    output rv_pkg::reg_idx_t       rs2_idx_ex_reg_o
);
    import rv_pkg::*;

    // data fields of the instruction in execute
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_ex_reg_o      <= '0;
            instr_ex_reg_o   <= '0;
            imm_ex_reg_o     <= '0;
            rs1_ex_reg_o     <= '0;
            rs2_ex_reg_o     <= '0;
            rs1_idx_ex_reg_o <= '0;
            rs2_idx_ex_reg_o <= '0;
        end else begin
            pc_ex_reg_o      <= pc_ex_reg_i;
            instr_ex_reg_o   <= instr_ex_reg_i;
            imm_ex_reg_o     <= imm_ex_reg_i;
            rs1_ex_reg_o     <= rs1_ex_reg_i;
            rs2_ex_reg_o     <= rs2_ex_reg_i;
            rs1_idx_ex_reg_o <= rs1_idx_ex_reg_i;
            rs2_idx_ex_reg_o <= rs2_idx_ex_reg_i;
        end
    end

    // control fields, reset gives a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aluctr_ex_reg_o  <= ALU_ADD;
            is_jalr_ex_reg_o <= 1'b0;
            is_jal_ex_reg_o  <= 1'b0;
            is_brc_ex_reg_o  <= 1'b0;
            src1sel_ex_reg_o <= SRC1_RS1;
            src2sel_ex_reg_o <= SRC2_RS2;
            wben_ex_reg_o    <= 1'b0;
        end else begin
            aluctr_ex_reg_o  <= aluctr_ex_reg_i;
            is_jalr_ex_reg_o <= is_jalr_ex_reg_i;
            is_jal_ex_reg_o  <= is_jal_ex_reg_i;
            is_brc_ex_reg_o  <= is_brc_ex_reg_i;
            src1sel_ex_reg_o <= src1sel_ex_reg_i;
            src2sel_ex_reg_o <= src2sel_ex_reg_i;
            wben_ex_reg_o    <= wben_ex_reg_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire rv_pkg::xlen_t     pc_i,
    input  wire rv_pkg::inst_t     instr_i,
    input  wire rv_pkg::xlen_t     imm_i,
    input  wire rv_pkg::xlen_t     rs1_i,
    input  wire rv_pkg::xlen_t     rs2_i,
    input  wire rv_pkg::alu_op_e   aluctr_i,
    input  wire logic              is_jalr_i,
    input  wire logic              is_jal_i,
    input  wire logic              is_brc_i,
    input  wire rv_pkg::src1_sel_e src1sel_i,
    input  wire rv_pkg::src2_sel_e src2sel_i,
    input  wire logic              wben_i,
    input  wire rv_pkg::reg_idx_t  rs1_idx_i,
    input  wire rv_pkg::reg_idx_t  rs2_idx_i,
    output logic                   wb_en_o,
    output rv_pkg::reg_idx_t       wb_rd_o,
    output rv_pkg::xlen_t          wb_data_o,
    output logic                   redirect_o,
    output rv_pkg::xlen_t          target_o
);
    import rv_pkg::*;

    xlen_t rs1_fwd;
    xlen_t rs2_fwd;
    xlen_t op_a;
    xlen_t op_b;
    xlen_t alu_res;
    xlen_t jalr_sum;
    xlen_t target;
    logic  redirect;

    // previous instruction has not reached the register file yet
    assign rs1_fwd = (wb_en_o && wb_rd_o == rs1_idx_i) ? wb_data_o : rs1_i;
    assign rs2_fwd = (wb_en_o && wb_rd_o == rs2_idx_i) ? wb_data_o : rs2_i;

    assign op_a = (src1sel_i == SRC1_PC) ? pc_i : rs1_fwd;

    always_comb begin
        case (src2sel_i)
            SRC2_IMM:  op_b = imm_i;
            SRC2_FOUR: op_b = xlen_t'(4);
            default:   op_b = rs2_fwd;
        endcase
    end

    // compares leave their result in bit 0
    always_comb begin
        case (aluctr_i)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << op_b[4:0];
            ALU_SLT:    alu_res = xlen_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_res = xlen_t'(op_a < op_b);
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> op_b[4:0];
            ALU_SRA:    alu_res = xlen_t'($signed(op_a) >>> op_b[4:0]);
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            ALU_EQ:     alu_res = xlen_t'(op_a == op_b);
            ALU_NE:     alu_res = xlen_t'(op_a != op_b);
            ALU_LT:     alu_res = xlen_t'($signed(op_a) < $signed(op_b));
            ALU_GE:     alu_res = xlen_t'($signed(op_a) >= $signed(op_b));
            ALU_LTU:    alu_res = xlen_t'(op_a < op_b);
            ALU_GEU:    alu_res = xlen_t'(op_a >= op_b);
            default:    alu_res = '0;
        endcase
    end

    // jalr target with bit 0 cleared
    assign jalr_sum = rs1_fwd + imm_i;
    assign target   = is_jalr_i ? {jalr_sum[XLEN-1:1], 1'b0} : pc_i + imm_i;
    assign redirect = is_jal_i || is_jalr_i || (is_brc_i && alu_res[0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en_o    <= 1'b0;
            wb_rd_o    <= '0;
            wb_data_o  <= '0;
            redirect_o <= 1'b0;
            target_o   <= '0;
        end else begin
            wb_en_o    <= wben_i;
            wb_rd_o    <= wben_i ? instr_i[11:7] : '0;
            wb_data_o  <= wben_i ? alu_res : '0;
            redirect_o <= redirect;
            target_o   <= redirect ? target : '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/id_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module id_decode (
    input  wire logic              instr_valid_i,
    input  wire rv_pkg::inst_t     instr_i,
    input  wire rv_pkg::xlen_t     pc_i,
    output rv_pkg::reg_idx_t       rs1_idx_o,
    output rv_pkg::reg_idx_t       rs2_idx_o,
    output rv_pkg::xlen_t          pc_o,
    output rv_pkg::inst_t          instr_o,
    output rv_pkg::xlen_t          imm_o,
    output rv_pkg::alu_op_e        aluctr_o,
    output rv_pkg::src1_sel_e      src1sel_o,
    output rv_pkg::src2_sel_e      src2sel_o,
    output logic                   is_jal_o,
    output logic                   is_jalr_o,
    output logic                   is_brc_o,
    output logic                   wben_o
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    logic       f7_ok;
    logic       shift;
    logic       writes;
    reg_idx_t   rd;
    xlen_t      imm_i;
    xlen_t      imm_u;
    xlen_t      imm_j;
    xlen_t      imm_b;
    alu_op_e    op_alu;
    alu_op_e    op_brc;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign alt    = instr_i[30];
    assign rd     = instr_i[11:7];

    assign rs1_idx_o = instr_i[19:15];
    assign rs2_idx_o = instr_i[24:20];
    assign pc_o      = pc_i;
    assign instr_o   = instr_i;

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

    // funct7 is zero, or 0x20 for sub and sra
    assign f7_ok = (instr_i[31:25] == 7'h00) ||
                   (instr_i[31:25] == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
    assign shift = (funct3[1:0] == 2'b01);

    // shared by OP and OP-IMM, no subtract on the immediate form
    always_comb begin
        case (funct3)
            3'b000:  op_alu = (alt && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
            3'b001:  op_alu = ALU_SLL;
            3'b010:  op_alu = ALU_SLT;
            3'b011:  op_alu = ALU_SLTU;
            3'b100:  op_alu = ALU_XOR;
            3'b101:  op_alu = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op_alu = ALU_OR;
            default: op_alu = ALU_AND;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  op_brc = ALU_EQ;
            3'b001:  op_brc = ALU_NE;
            3'b100:  op_brc = ALU_LT;
            3'b101:  op_brc = ALU_GE;
            3'b110:  op_brc = ALU_LTU;
            default: op_brc = ALU_GEU;
        endcase
    end

    always_comb begin
        imm_o     = '0;
        aluctr_o  = ALU_ADD;
        src1sel_o = SRC1_RS1;
        src2sel_o = SRC2_RS2;
        is_jal_o  = 1'b0;
        is_jalr_o = 1'b0;
        is_brc_o  = 1'b0;
        writes    = 1'b0;
        case (opcode)
            OPC_OP: begin
                aluctr_o = op_alu;
                writes   = f7_ok;
            end
            OPC_OP_IMM: begin
                imm_o     = imm_i;
                aluctr_o  = op_alu;
                src2sel_o = SRC2_IMM;
                writes    = !shift || f7_ok;
            end
            OPC_LUI: begin
                imm_o     = imm_u;
                aluctr_o  = ALU_PASS_B;
                src2sel_o = SRC2_IMM;
                writes    = 1'b1;
            end
            OPC_AUIPC: begin
                imm_o     = imm_u;
                src1sel_o = SRC1_PC;
                src2sel_o = SRC2_IMM;
                writes    = 1'b1;
            end
            // jumps write the link value pc + 4
            OPC_JAL: begin
                imm_o     = imm_j;
                src1sel_o = SRC1_PC;
                src2sel_o = SRC2_FOUR;
                is_jal_o  = 1'b1;
                writes    = 1'b1;
            end
            OPC_JALR: begin
                imm_o     = imm_i;
                src1sel_o = SRC1_PC;
                src2sel_o = SRC2_FOUR;
                is_jalr_o = (funct3 == 3'b000);
                writes    = (funct3 == 3'b000);
            end
            OPC_BRANCH: begin
                imm_o    = imm_b;
                aluctr_o = op_brc;
                is_brc_o = (funct3[2:1] != 2'b01);
            end
            default: ;
        endcase
        // invalid cycle becomes a bubble
        if (!instr_valid_i) begin
            is_jal_o  = 1'b0;
            is_jalr_o = 1'b0;
            is_brc_o  = 1'b0;
            writes    = 1'b0;
        end
    end

    // x0 is never written, a jump to x0 still redirects
    assign wben_o = writes && (rd != '0);

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire rv_pkg::reg_idx_t rs1_idx_i,
    input  wire rv_pkg::reg_idx_t rs2_idx_i,
    output rv_pkg::xlen_t         rs1_data_o,
    output rv_pkg::xlen_t         rs2_data_o,
    input  wire logic             we_i,
    input  wire rv_pkg::reg_idx_t wr_idx_i,
    input  wire rv_pkg::xlen_t    wr_data_i
);
    import rv_pkg::*;

    // x0 has no storage
    xlen_t regs [1:NREG-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wr_idx_i != '0) begin
            regs[wr_idx_i] <= wr_data_i;
        end
    end

    // write-through, a read in the writing cycle sees the new value
    always_comb begin
        if (rs1_idx_i == '0) begin
            rs1_data_o = '0;
        end else if (we_i && wr_idx_i == rs1_idx_i) begin
            rs1_data_o = wr_data_i;
        end else begin
            rs1_data_o = regs[rs1_idx_i];
        end
    end

    always_comb begin
        if (rs2_idx_i == '0) begin
            rs2_data_o = '0;
        end else if (we_i && wr_idx_i == rs2_idx_i) begin
            rs2_data_o = wr_data_i;
        end else begin
            rs2_data_o = regs[rs2_idx_i];
        end
    end

endmodule

`default_nettype wire

/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;
    localparam int ILEN = 32;
    localparam int NREG = 32;

    typedef logic [XLEN-1:0]         xlen_t;
    typedef logic [ILEN-1:0]         inst_t;
    typedef logic [$clog2(NREG)-1:0] reg_idx_t;

    // arithmetic group first, then the branch compares
    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_SLL    = 5'd2,
        ALU_SLT    = 5'd3,
        ALU_SLTU   = 5'd4,
        ALU_XOR    = 5'd5,
        ALU_SRL    = 5'd6,
        ALU_SRA    = 5'd7,
        ALU_OR     = 5'd8,
        ALU_AND    = 5'd9,
        ALU_PASS_B = 5'd10,
        ALU_EQ     = 5'd16,
        ALU_NE     = 5'd17,
        ALU_LT     = 5'd18,
        ALU_GE     = 5'd19,
        ALU_LTU    = 5'd20,
        ALU_GEU    = 5'd21
    } alu_op_e;

    typedef enum logic {
        SRC1_RS1 = 1'b0,
        SRC1_PC  = 1'b1
    } src1_sel_e;

    typedef enum logic [1:0] {
        SRC2_RS2  = 2'd0,
        SRC2_IMM  = 2'd1,
        SRC2_FOUR = 2'd2
    } src2_sel_e;

    // major opcodes, instr[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

endpackage

`default_nettype wire

/* src.f */
hdl/rv_pkg.sv
hdl/id_decode.sv
hdl/reg_file.sv
hdl/ex_reg.sv
hdl/ex_stage.sv
hdl/core_id_ex.sv
testbench/core_id_ex_assertions.sv
testbench/core_id_ex_tb.sv

/* testbench/core_id_ex_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module core_id_ex_assertions (
    input wire logic             clk,
    input wire logic             rst_n,
    input wire logic             wb_en_i,
    input wire rv_pkg::reg_idx_t wb_rd_i,
    input wire rv_pkg::xlen_t    wb_data_i,
    input wire logic             redirect_i,
    input wire rv_pkg::xlen_t    target_i
);

    // number of failed assertions
    int unsigned fail_count = 0;

    // x0 is never a destination
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wb_en_i |-> wb_rd_i != '0)
        else begin
            fail_count++;
            $error("write enable seen with destination x0");
        end

    a_target_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_i |-> !target_i[0])
        else begin
            fail_count++;
            $error("redirect target has bit 0 set");
        end

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> (!wb_en_i && wb_rd_i == '0 && wb_data_i == '0 &&
                    !redirect_i && target_i == '0))
        else begin
            fail_count++;
            $error("outputs not cleared during reset");
        end

    a_wb_en_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(wb_en_i))
        else begin
            fail_count++;
            $error("write enable is unknown");
        end

endmodule

bind core_id_ex core_id_ex_assertions u_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_en_i    (wb_en_o),
    .wb_rd_i    (wb_rd_o),
    .wb_data_i  (wb_data_o),
    .redirect_i (redirect_o),
    .target_i   (target_o)
);

`default_nettype wire

/* testbench/core_id_ex_cases.txt */
// instr    pc       valid    wb_en    rd       wb_data  redirect target
// target is only compared when redirect is expected
FFB00093 00000100 00000001 00000001 00000001 FFFFFFFB 00000000 00000000
00C00113 00000104 00000001 00000001 00000002 0000000C 00000000 00000000
123451B7 00000108 00000001 00000001 00000003 12345000 00000000 00000000
00001217 0000010C 00000001 00000001 00000004 0000110C 00000000 00000000
002082B3 00000110 00000001 00000001 00000005 00000007 00000000 00000000
40128333 00000114 00000001 00000001 00000006 0000000C 00000000 00000000
002193B3 00000118 00000001 00000001 00000007 45000000 00000000 00000000
0060D433 0000011C 00000001 00000001 00000008 000FFFFF 00000000 00000000
4060D4B3 00000120 00000001 00000001 00000009 FFFFFFFF 00000000 00000000
0020A533 00000124 00000001 00000001 0000000A 00000001 00000000 00000000
0020B5B3 00000128 00000001 00000001 0000000B 00000000 00000000 00000000
0041C633 0000012C 00000001 00000001 0000000C 1234410C 00000000 00000000
001676B3 00000130 00000001 00000001 0000000D 12344108 00000000 00000000
0032E733 00000134 00000001 00000001 0000000E 12345007 00000000 00000000
00610863 00000138 00000001 00000000 00000000 00000000 00000001 00000148
00208863 0000013C 00000001 00000000 00000000 00000000 00000000 00000000
FE209CE3 00000140 00000001 00000000 00000000 00000000 00000001 00000138
00611863 00000144 00000001 00000000 00000000 00000000 00000000 00000000
0020C863 00000148 00000001 00000000 00000000 00000000 00000001 00000158
00114863 0000014C 00000001 00000000 00000000 00000000 00000000 00000000
00115863 00000150 00000001 00000000 00000000 00000000 00000001 00000160
0050D863 00000154 00000001 00000000 00000000 00000000 00000000 00000000
FE116CE3 00000158 00000001 00000000 00000000 00000000 00000001 00000150
0020E863 0000015C 00000001 00000000 00000000 00000000 00000000 00000000
0020F863 00000160 00000001 00000000 00000000 00000000 00000001 00000170
0062F863 00000164 00000001 00000000 00000000 00000000 00000000 00000000
020007EF 00000168 00000001 00000001 0000000F 0000016C 00000001 00000188
00578867 0000016C 00000001 00000001 00000010 00000170 00000001 00000170
00100893 00000170 00000000 00000000 00000000 00000000 00000000 00000000
0000A903 00000174 00000001 00000000 00000000 00000000 00000000 00000000
00710013 00000178 00000001 00000000 00000000 00000000 00000000 00000000
005009B3 0000017C 00000001 00000001 00000013 00000007 00000000 00000000

/* testbench/core_id_ex_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_id_ex_tb;
    import rv_pkg::*;

    localparam int NUM_CASES = 32;
    localparam int WORDS     = 8;
    localparam int MAX_WAIT  = 20;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     instr_valid;
    inst_t    instr;
    xlen_t    pc;
    logic     wb_en;
    reg_idx_t wb_rd;
    xlen_t    wb_data;
    logic     redirect;
    xlen_t    target;

    // eight words per case in the order of the cases file header
    logic [31:0] case_words [0:NUM_CASES*WORDS-1];

    // case index presented at the last three rising edges
    int issue_idx = -1;
    int age0 = -1;
    int age1 = -1;
    int age2 = -1;
    int checked = 0;
    int wait_cycles;

    core_id_ex UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .pc_i          (pc),
        .wb_en_o       (wb_en),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data),
        .redirect_o    (redirect),
        .target_o      (target)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_wb(input int idx, input logic exp_en, input reg_idx_t exp_rd,
                            input xlen_t exp_data);
        // rd and data only matter for a real write
        if (wb_en !== exp_en || (exp_en && (wb_rd !== exp_rd || wb_data !== exp_data))) begin
            abort_run($sformatf("Fail %0t: case %0d writeback en=%0b rd=%0d data=%h, %s",
                                $time, idx, wb_en, wb_rd, wb_data,
                                $sformatf("expected en=%0b rd=%0d data=%h",
                                          exp_en, exp_rd, exp_data)));
        end
    endtask

    task automatic check_redirect(input int idx, input logic exp_redirect,
                                  input xlen_t exp_target);
        if (redirect !== exp_redirect || (exp_redirect && target !== exp_target)) begin
            abort_run($sformatf("Fail %0t: case %0d redirect=%0b target=%h, %s",
                                $time, idx, redirect, target,
                                $sformatf("expected redirect=%0b target=%h",
                                          exp_redirect, exp_target)));
        end
    endtask

    task automatic check_case(input int idx);
        int base;
        base = idx * WORDS;
        check_wb(idx, case_words[base+3][0], case_words[base+4][4:0], case_words[base+5]);
        check_redirect(idx, case_words[base+6][0], case_words[base+7]);
    endtask

    // results of a case appear two edges after it is driven
    always @(negedge clk) begin
        age2 = age1;
        age1 = age0;
        age0 = issue_idx;
        if (age2 >= 0) begin
            check_case(age2);
            checked = checked + 1;
        end
    end

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        $readmemh("testbench/core_id_ex_cases.txt", case_words);
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < NUM_CASES; i++) begin
            @(posedge clk);
            instr       <= case_words[i*WORDS];
            pc          <= case_words[i*WORDS+1];
            instr_valid <= case_words[i*WORDS+2][0];
            issue_idx = i;
        end

        // drain the pipeline with invalid cycles
        @(posedge clk);
        instr_valid <= 1'b0;
        instr       <= '0;
        issue_idx = -1;
        wait_cycles = 0;
        while (checked < NUM_CASES) begin
            @(posedge clk);
            wait_cycles = wait_cycles + 1;
            if (wait_cycles > MAX_WAIT) begin
                abort_run("timed out waiting for the last results to leave the pipeline");
            end
        end

        if (UUT.u_assertions.fail_count != 0) begin
            abort_run("a bound assertion on the outputs failed during the run");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
